/* compile.f */
logic/acq_pkg.sv
logic/calib_cfg_if.sv
logic/calib_regs.sv
logic/adc_capture.sv
logic/linear_calib.sv
logic/dac_output.sv
logic/analog_front_top.sv
testbench/tb_analog_front.sv

/* logic/acq_pkg.sv */
////////////////////
// acquisition package
// widths, sample and calibration types, register map,
// reset values and the register block FSM states
////////////////////

package acq_pkg;

  // sample and gain widths
  localparam int SMP_W     = 14;
  localparam int GAIN_W    = 16;
  // fixed point position of the gain
  localparam int GAIN_FRAC = 14;

  // raw converter code, offset binary with inverted slope
  typedef logic        [SMP_W-1:0]  adc_code_t;
  // signed sample
  typedef logic signed [SMP_W-1:0]  smp_t;
  // calibration gain and offset
  typedef logic signed [GAIN_W-1:0] gain_t;
  typedef logic signed [SMP_W-1:0]  offset_t;

  // configuration port
  typedef logic [3:0]  cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  // unity gain
  localparam gain_t   GAIN_RESET   = gain_t'(16384);
  localparam offset_t OFFSET_RESET = '0;

  ////////////////////
  // register map
  ////////////////////

  // loopback enables, one bit per channel
  localparam cfg_addr_t CFG_ADDR_LOOP    = 4'd0;
  // channel 0 calibration, channel 1 is one step higher
  localparam cfg_addr_t CFG_ADDR_ADC_MUL = 4'd1;
  localparam cfg_addr_t CFG_ADDR_ADC_SUM = 4'd2;
  localparam cfg_addr_t CFG_ADDR_DAC_MUL = 4'd3;
  localparam cfg_addr_t CFG_ADDR_DAC_SUM = 4'd4;
  localparam cfg_addr_t CFG_CHN_STEP     = 4'd4;

  // handshake FSM
  typedef enum logic {
    IDLE,
    ACK
  } cfg_state_t;

  // keep top bit, invert the rest
  // the same rule works both ways between code and sample
  function automatic smp_t code_to_smp(adc_code_t code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

  function automatic adc_code_t smp_to_code(smp_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

endpackage

/* logic/adc_capture.sv */
////////////////////
// ADC capture
// input register with code to sample conversion,
// then the digital loopback mux per channel
////////////////////

`timescale 1ns/1ps

module adc_capture #(
  parameter int CHN = 2
) (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // raw converter codes
  input  acq_pkg::adc_code_t [CHN-1:0]  adc_dat_i,
  // calibrated generator samples
  input  acq_pkg::smp_t      [CHN-1:0]  loop_dat_i,
  calib_cfg_if.capture                  cfg,
  // samples toward the calibration
  output acq_pkg::smp_t      [CHN-1:0]  smp_o
);

  import acq_pkg::*;

  smp_t [CHN-1:0] adc_smp_q;

  // input register, converted on the way in
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_smp_q <= '0;
    end else begin
      for (int ch = 0; ch < CHN; ch++) begin
        adc_smp_q[ch] <= code_to_smp(adc_dat_i[ch]);
      end
    end
  end

  // loopback select after the register
  always_comb begin
    for (int ch = 0; ch < CHN; ch++) begin
      if (cfg.loop[ch]) begin
        smp_o[ch] = loop_dat_i[ch];
      end else begin
        smp_o[ch] = adc_smp_q[ch];
      end
    end
  end

endmodule

/* logic/analog_front_top.sv */
////////////////////
// analog front top
// ADC capture and calibration, generator calibration,
// DAC interleave and the calibration registers
////////////////////

`timescale 1ns/1ps

module analog_front_top #(
  parameter int CHN = 2
) (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // ADC
  input  acq_pkg::adc_code_t [CHN-1:0]  adc_dat_i,
  // generator samples
  input  acq_pkg::smp_t      [CHN-1:0]  gen_dat_i,
  // configuration write port
  input  logic                          cfg_req_i,
  input  acq_pkg::cfg_addr_t            cfg_addr_i,
  input  acq_pkg::cfg_data_t            cfg_wdata_i,
  output logic                          cfg_ack_o,
  // calibrated acquisition samples
  output acq_pkg::smp_t      [CHN-1:0]  acq_dat_o,
  // DAC
  output acq_pkg::adc_code_t            dac_dat_o,
  output logic                          dac_sel_o,
  output logic                          dac_rst_o
);

  import acq_pkg::*;

  // capture output, ADC or loopback
  smp_t [CHN-1:0] cap_smp;
  // calibrated generator samples
  smp_t [CHN-1:0] dac_smp;

  calib_cfg_if #(.CHN(CHN)) cfg_if ();

  ////////////////////
  // configuration
  ////////////////////

  calib_regs #(.CHN(CHN)) i_calib_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_req_i   (cfg_req_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg         (cfg_if.regs)
  );

  ////////////////////
  // acquisition side
  ////////////////////

  // loopback takes the generator after its calibration
  adc_capture #(.CHN(CHN)) i_adc_capture (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_dat_i (dac_smp),
    .cfg        (cfg_if.capture),
    .smp_o      (cap_smp)
  );

  for (genvar ch = 0; ch < CHN; ch++) begin : g_chn
    // acquisition calibration
    linear_calib i_adc_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (cap_smp[ch]),
      .mul_i   (cfg_if.adc_mul[ch]),
      .sum_i   (cfg_if.adc_sum[ch]),
      .smp_o   (acq_dat_o[ch])
    );

    // generator calibration
    linear_calib i_dac_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (gen_dat_i[ch]),
      .mul_i   (cfg_if.dac_mul[ch]),
      .sum_i   (cfg_if.dac_sum[ch]),
      .smp_o   (dac_smp[ch])
    );
  end

  ////////////////////
  // generator side
  ////////////////////

  dac_output i_dac_output (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .smp_i     (dac_smp),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

/* logic/calib_cfg_if.sv */
////////////////////
// calibration config interface
// loopback enables, gains and offsets per channel,
// from the register block to the datapath
////////////////////

`timescale 1ns/1ps

interface calib_cfg_if #(
  parameter int CHN = 2
);

  import acq_pkg::*;

  // digital loopback enable per channel
  logic    [CHN-1:0] loop;
  // acquisition side calibration
  gain_t   [CHN-1:0] adc_mul;
  offset_t [CHN-1:0] adc_sum;
  // generator side calibration
  gain_t   [CHN-1:0] dac_mul;
  offset_t [CHN-1:0] dac_sum;

  // register block drives everything
  modport regs (
    output loop,
    output adc_mul,
    output adc_sum,
    output dac_mul,
    output dac_sum
  );

  // capture only needs the loopback enables
  modport capture (
    input loop
  );

endinterface

/* logic/calib_regs.sv */
////////////////////
// calibration register block
// write only registers behind a four phase req/ack port,
// loopback enables plus gain and offset per channel
////////////////////

`timescale 1ns/1ps

module calib_regs #(
  parameter int CHN = 2
) (
  input  logic                adc_clk,
  input  logic                top_rst,
  // configuration write port
  input  logic                cfg_req_i,
  input  acq_pkg::cfg_addr_t  cfg_addr_i,
  input  acq_pkg::cfg_data_t  cfg_wdata_i,
  output logic                cfg_ack_o,
  // register outputs
  calib_cfg_if.regs           cfg
);

  import acq_pkg::*;

  cfg_state_t state_q;
  logic       wr_en;

  ////////////////////
  // handshake
  ////////////////////

  // write happens on the edge that raises ack
  assign wr_en = (state_q == IDLE) && cfg_req_i;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        // wait for the master to raise req
        IDLE: begin
          if (cfg_req_i) begin
            state_q <= ACK;
          end
        end
        // hold ack until req drops
        ACK: begin
          if (!cfg_req_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign cfg_ack_o = (state_q == ACK);

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cfg.loop    <= '0;
      cfg.adc_mul <= {CHN{GAIN_RESET}};
      cfg.adc_sum <= {CHN{OFFSET_RESET}};
      cfg.dac_mul <= {CHN{GAIN_RESET}};
      cfg.dac_sum <= {CHN{OFFSET_RESET}};
    end else if (wr_en) begin
      // loopback enables in the low bits
      if (cfg_addr_i == CFG_ADDR_LOOP) begin
        cfg.loop <= cfg_wdata_i[CHN-1:0];
      end
      // per channel block of four, unknown addresses fall through
      for (int ch = 0; ch < CHN; ch++) begin
        if (cfg_addr_i == cfg_addr_t'(CFG_ADDR_ADC_MUL + CFG_CHN_STEP * ch)) begin
          cfg.adc_mul[ch] <= gain_t'(cfg_wdata_i);
        end
        if (cfg_addr_i == cfg_addr_t'(CFG_ADDR_ADC_SUM + CFG_CHN_STEP * ch)) begin
          // offsets take the low bits only
          cfg.adc_sum[ch] <= offset_t'(cfg_wdata_i[SMP_W-1:0]);
        end
        if (cfg_addr_i == cfg_addr_t'(CFG_ADDR_DAC_MUL + CFG_CHN_STEP * ch)) begin
          cfg.dac_mul[ch] <= gain_t'(cfg_wdata_i);
        end
        if (cfg_addr_i == cfg_addr_t'(CFG_ADDR_DAC_SUM + CFG_CHN_STEP * ch)) begin
          cfg.dac_sum[ch] <= offset_t'(cfg_wdata_i[SMP_W-1:0]);
        end
      end
    end
  end

endmodule

/* logic/dac_output.sv */
////////////////////
// DAC output
// sample to DAC code, both channels interleaved
// on one bus with a toggling select, plus DAC reset
////////////////////

`timescale 1ns/1ps

module dac_output (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // calibrated generator samples, channel 0 and 1
  input  acq_pkg::smp_t [1:0]     smp_i,
  // DAC bus
  output acq_pkg::adc_code_t      dac_dat_o,
  output logic                    dac_sel_o,
  output logic                    dac_rst_o
);

  import acq_pkg::*;

  adc_code_t code_c [2];

  // same bit rule as on the ADC side
  assign code_c[0] = smp_to_code(smp_i[0]);
  assign code_c[1] = smp_to_code(smp_i[1]);

  // DAC reset, released one edge after top reset
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

  ////////////////////
  // interleave
  ////////////////////

  // select flips every clock
  // new select 1 carries channel 0, new select 0 carries channel 1
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      dac_sel_o <= ~dac_sel_o;
      if (dac_sel_o) begin
        dac_dat_o <= code_c[1];
      end else begin
        dac_dat_o <= code_c[0];
      end
    end
  end

endmodule

/* logic/linear_calib.sv */
////////////////////
// linear calibration, one channel
// two stage pipe, product first,
// then shift, offset and saturation
////////////////////

`timescale 1ns/1ps

module linear_calib (
  input  logic              adc_clk,
  input  logic              top_rst,
  // sample in
  input  acq_pkg::smp_t     smp_i,
  // gain and offset
  input  acq_pkg::gain_t    mul_i,
  input  acq_pkg::offset_t  sum_i,
  // calibrated sample out
  output acq_pkg::smp_t     smp_o
);

  import acq_pkg::*;

  // full product width
  localparam int PRD_W = SMP_W + GAIN_W;
  // after dropping the fraction bits
  localparam int SHF_W = PRD_W - GAIN_FRAC;
  // one guard bit for the offset add
  localparam int ADD_W = SHF_W + 1;

  // saturation limits
  localparam smp_t SMP_MAX = smp_t'(8191);
  localparam smp_t SMP_MIN = smp_t'(-8192);

  logic signed [PRD_W-1:0] prd_q;
  logic signed [SHF_W-1:0] shf_c;
  logic signed [ADD_W-1:0] add_c;
  smp_t                    sat_c;

  // stage 1, signed product
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prd_q <= '0;
    end else begin
      prd_q <= smp_i * mul_i;
    end
  end

  // arithmetic shift by the fraction width
  assign shf_c = prd_q[PRD_W-1:GAIN_FRAC];
  // both signed, sign extended to the add width
  assign add_c = shf_c + sum_i;

  // clamp to the sample range
  always_comb begin
    if (add_c > SMP_MAX) begin
      sat_c = SMP_MAX;
    end else if (add_c < SMP_MIN) begin
      sat_c = SMP_MIN;
    end else begin
      sat_c = smp_t'(add_c);
    end
  end

  // stage 2
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else begin
      smp_o <= sat_c;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the analog front testbench with Verilator
# exit status is nonzero when the build breaks or the log holds the fail message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal \
  -f compile.f \
  --top-module tb_analog_front \
  -o tb_analog_front_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_analog_front_sim > sim.log 2>&1 \
  || echo "simulator exited with nonzero status" >> sim.log

cat sim.log

grep -q "SIMULATION FAILED" sim.log \
  && { echo "run_sim: failing run"; exit 1; } \
  || { echo "run_sim: no failure found in log"; exit 0; }

/* testbench/tb_analog_front.sv */
////////////////////
// analog front testbench
// reset, config handshake, ADC path, DAC interleave
// and loopback against reference models
////////////////////

`timescale 1ns/1ps

module tb_analog_front;

  import acq_pkg::*;

  localparam int CHN       = 2;
  localparam int PERIOD    = 100;
  localparam int DRV       = 5;
  localparam int RST_CYC   = 16;
  localparam int SETTLE    = 8;
  localparam int CHK       = 6;
  localparam int ACK_WAIT  = 8;
  localparam int NUM_TESTS = 7;
  // worst case writes per test, each bounded by two ack waits
  localparam int MAX_WR    = 8;
  localparam int TIMEOUT_CYC = RST_CYC + 200
    + NUM_TESTS * (SETTLE + CHK + MAX_WR * (2 * ACK_WAIT + 2));

  logic                  adc_clk = 1'b0;
  logic                  top_rst;
  adc_code_t [CHN-1:0]   adc_dat_i;
  smp_t      [CHN-1:0]   gen_dat_i;
  logic                  cfg_req_i;
  cfg_addr_t             cfg_addr_i;
  cfg_data_t             cfg_wdata_i;
  logic                  cfg_ack_o;
  smp_t      [CHN-1:0]   acq_dat_o;
  adc_code_t             dac_dat_o;
  logic                  dac_sel_o;
  logic                  dac_rst_o;

  // register model
  logic [CHN-1:0] m_loop;
  gain_t          m_adc_mul [CHN];
  offset_t        m_adc_sum [CHN];
  gain_t          m_dac_mul [CHN];
  offset_t        m_dac_sum [CHN];

  // expected outputs and bookkeeping
  smp_t      exp_acq [CHN];
  adc_code_t exp_dac [CHN];
  adc_code_t dac_exp;
  logic      chk_en = 1'b0;
  string     test_name;
  int        test_errs;
  int        tests_run;
  int        tests_failed;
  logic      prev_sel;
  int        lb_ch;

  analog_front_top #(.CHN(CHN)) dut0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .gen_dat_i   (gen_dat_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .acq_dat_o   (acq_dat_o),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o),
    .dac_rst_o   (dac_rst_o)
  );

  always #(PERIOD / 2) adc_clk = ~adc_clk;

  ////////////////////
  // reference models
  ////////////////////

  // top bit kept, lower bits inverted, both directions
  function automatic logic [SMP_W-1:0] flip_bits(input logic [SMP_W-1:0] v);
    return {v[SMP_W-1], ~v[SMP_W-2:0]};
  endfunction

  // product, floor shift by 14, offset, clamp
  function automatic smp_t calib_ref(input smp_t s, input gain_t g, input offset_t o);
    longint acc;
    acc = longint'(s) * longint'(g);
    acc = acc >>> 14;
    acc = acc + longint'(o);
    if (acc > 8191) begin
      acc = 8191;
    end else if (acc < -8192) begin
      acc = -8192;
    end
    return smp_t'(acc);
  endfunction

  ////////////////////
  // compare process
  ////////////////////

  // outputs are settled at the falling edge
  always @(negedge adc_clk) begin
    if (chk_en) begin
      for (int ch = 0; ch < CHN; ch++) begin
        if (acq_dat_o[ch] !== exp_acq[ch]) begin
          test_errs++;
          $display("[ERROR] %s acq ch%0d expected %0d actual %0d",
                   test_name, ch, exp_acq[ch], acq_dat_o[ch]);
        end
      end
      // select 1 carries channel 0
      dac_exp = dac_sel_o ? exp_dac[0] : exp_dac[1];
      if (dac_dat_o !== dac_exp) begin
        test_errs++;
        $display("[ERROR] %s dac sel %0b expected 0x%h actual 0x%h",
                 test_name, dac_sel_o, dac_exp, dac_dat_o);
      end
    end
  end

  ////////////////////
  // helper tasks
  ////////////////////

  // four phase write, called and left at drive time
  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    int n;
    if (cfg_ack_o !== 1'b0) begin
      test_errs++;
      $display("%s: ack was already high before req rose at address %0d", test_name, addr);
    end
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    cfg_req_i   = 1'b1;
    n = 0;
    while (cfg_ack_o !== 1'b1 && n < ACK_WAIT) begin
      @(posedge adc_clk);
      #DRV;
      n++;
    end
    if (cfg_ack_o !== 1'b1) begin
      test_errs++;
      $display("%s: ack never rose for write to address %0d", test_name, addr);
    end
    cfg_req_i = 1'b0;
    n = 0;
    while (cfg_ack_o !== 1'b0 && n < ACK_WAIT) begin
      @(posedge adc_clk);
      #DRV;
      n++;
    end
    if (cfg_ack_o !== 1'b0) begin
      test_errs++;
      $display("%s: ack stayed high after req dropped at address %0d", test_name, addr);
    end
  endtask

  // gain at 1 + 4*ch, offset next; upper offset bits are junk
  task automatic set_adc_cal(input int ch, input gain_t g, input offset_t o);
    cfg_write(cfg_addr_t'(1 + 4 * ch), cfg_data_t'(g));
    cfg_write(cfg_addr_t'(2 + 4 * ch), {2'($urandom), o});
    m_adc_mul[ch] = g;
    m_adc_sum[ch] = o;
  endtask

  task automatic set_dac_cal(input int ch, input gain_t g, input offset_t o);
    cfg_write(cfg_addr_t'(3 + 4 * ch), cfg_data_t'(g));
    cfg_write(cfg_addr_t'(4 + 4 * ch), {2'($urandom), o});
    m_dac_mul[ch] = g;
    m_dac_sum[ch] = o;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  // expected values from the model, settle, then compare
  task automatic run_check();
    smp_t gen_cal;
    for (int ch = 0; ch < CHN; ch++) begin
      gen_cal     = calib_ref(gen_dat_i[ch], m_dac_mul[ch], m_dac_sum[ch]);
      exp_dac[ch] = flip_bits(gen_cal);
      if (m_loop[ch]) begin
        exp_acq[ch] = calib_ref(gen_cal, m_adc_mul[ch], m_adc_sum[ch]);
      end else begin
        exp_acq[ch] = calib_ref(flip_bits(adc_dat_i[ch]), m_adc_mul[ch], m_adc_sum[ch]);
      end
    end
    repeat (SETTLE) @(posedge adc_clk);
    #DRV;
    chk_en = 1'b1;
    repeat (CHK) @(posedge adc_clk);
    #DRV;
    chk_en = 1'b0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %s %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "bad",
             test_errs);
  endtask

  task automatic new_inputs();
    for (int ch = 0; ch < CHN; ch++) begin
      adc_dat_i[ch] = adc_code_t'($urandom);
      gen_dat_i[ch] = smp_t'($urandom);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    void'($urandom(32'h3506));
    top_rst      = 1'b1;
    adc_dat_i    = '0;
    gen_dat_i    = '0;
    cfg_req_i    = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    tests_run    = 0;
    tests_failed = 0;
    m_loop       = '0;
    for (int ch = 0; ch < CHN; ch++) begin
      m_adc_mul[ch] = 16'sd16384;
      m_adc_sum[ch] = '0;
      m_dac_mul[ch] = 16'sd16384;
      m_dac_sum[ch] = '0;
    end

    // reset, then DAC reset release and select toggling
    start_test("reset");
    repeat (RST_CYC) @(posedge adc_clk);
    #DRV;
    if (cfg_ack_o !== 1'b0 || dac_rst_o !== 1'b1) begin
      test_errs++;
      $display("[ERROR] reset ack/dac_rst expected 0/1 actual %b/%b", cfg_ack_o, dac_rst_o);
    end
    top_rst = 1'b0;
    @(posedge adc_clk);
    #DRV;
    if (dac_rst_o !== 1'b0) begin
      test_errs++;
      $display("[ERROR] reset dac_rst after first edge expected 0 actual %b", dac_rst_o);
    end
    prev_sel = dac_sel_o;
    repeat (4) begin
      @(posedge adc_clk);
      #DRV;
      if (dac_sel_o === prev_sel) begin
        test_errs++;
        $display("[ERROR] reset dac_sel expected %b actual %b", ~prev_sel, dac_sel_o);
      end
      prev_sel = dac_sel_o;
    end
    end_test();

    // unity gain, zero offset
    start_test("adc_default");
    new_inputs();
    run_check();
    end_test();

    start_test("adc_random_cal");
    for (int ch = 0; ch < CHN; ch++) begin
      set_adc_cal(ch, gain_t'($urandom), offset_t'($urandom));
    end
    new_inputs();
    run_check();
    end_test();

    // near full scale times almost two, both limits
    start_test("adc_saturation");
    for (int ch = 0; ch < CHN; ch++) begin
      set_adc_cal(ch, 16'sh7fff, offset_t'(0));
    end
    adc_dat_i[0] = flip_bits(14'sd8000);
    adc_dat_i[1] = flip_bits(-14'sd8000);
    run_check();
    end_test();

    // unmapped addresses must leave the datapath alone
    start_test("cfg_unused_addr");
    cfg_write(4'd9, cfg_data_t'($urandom));
    cfg_write(4'd15, cfg_data_t'($urandom));
    run_check();
    end_test();

    start_test("dac_interleave");
    for (int ch = 0; ch < CHN; ch++) begin
      set_dac_cal(ch, gain_t'($urandom), offset_t'($urandom));
    end
    new_inputs();
    run_check();
    end_test();

    // one channel looped, the other stays on its ADC
    start_test("loopback");
    // unity ADC gain and a small offset keep the loop result off the limits
    for (int ch = 0; ch < CHN; ch++) begin
      set_adc_cal(ch, 16'sd16384, offset_t'($urandom_range(255, 0)));
    end
    lb_ch = $urandom_range(1, 0);
    cfg_write(4'd0, cfg_data_t'(1 << lb_ch));
    m_loop = CHN'(1 << lb_ch);
    new_inputs();
    run_check();
    end_test();

    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0 && tests_run == NUM_TESTS) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_CYC * PERIOD);
    $display("watchdog expired after %0d cycles, tests did not complete", TIMEOUT_CYC);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
